/* dv/rmw_checker.sv */
//----------------------------------------------------------------------------
// RMW converter protocol checker
// Handshake stability and read-modify-write rules on the converter ports
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_checker (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_cmd_valid,
  input  var logic                           i_cmd_accept,
  input  var rmw_pkg::bus_cmd_e              i_cmd,
  input  var logic [rmw_pkg::ID_W-1:0]       i_id,
  input  var logic [rmw_pkg::ADDR_W-1:0]     i_addr,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_data,
  input  var logic                           i_mst_resp_valid,
  input  var logic                           i_mst_resp_accept,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_mst_resp_data,
  input  var logic                           i_resp_valid,
  input  var logic                           i_resp_accept,
  input  var rmw_pkg::bus_resp_e             i_resp,
  input  var logic [rmw_pkg::ID_W-1:0]       i_resp_id,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_resp_data,
  input  var rmw_pkg::rmw_state_e            i_state,
  input  var logic [rmw_pkg::BYTEEN_W-1:0]   i_head_byteen,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_head_data
);
  import rmw_pkg::*;

  int unsigned         fail_cnt = 0;
  logic [NP_CNT_W-1:0] np_open;
  logic                np_issue;
  logic                np_done;
  logic [DATA_W-1:0]   old_word;
  logic [DATA_W-1:0]   byte_mask;

  // Outstanding reads and non-posted writes seen on the master ports
  assign np_issue = i_cmd_valid && i_cmd_accept && (i_cmd != CMD_WRITE);
  assign np_done  = i_mst_resp_valid && i_mst_resp_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      np_open <= '0;
    end else begin
      np_open <= np_open + NP_CNT_W'(np_issue) - NP_CNT_W'(np_done);
    end
  end

  // Old word as returned for the RMW read
  always_ff @(posedge i_clk) begin
    if ((i_state == ST_WAIT_READ) && np_done) begin
      old_word <= i_mst_resp_data;
    end
  end

  always_comb begin
    for (int b = 0; b < BYTEEN_W; b++) begin
      byte_mask[8*b+:8] = {8{i_head_byteen[b]}};
    end
  end

  // Master command holds with stable payload until accepted
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_cmd_valid && !i_cmd_accept |=> i_cmd_valid && $stable({i_cmd, i_id, i_addr, i_data}))
    else begin
      $error("Master command changed before it was accepted");
      fail_cnt++;
    end

  // Slave response holds the same way
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_resp_valid && !i_resp_accept |=> i_resp_valid && $stable({i_resp, i_resp_id, i_resp_data}))
    else begin
      $error("Slave response changed before it was accepted");
      fail_cnt++;
    end

  // Merged write is a whole word, new bytes where enabled and old bytes elsewhere
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_state == ST_WRITE_MERGED) && i_cmd_valid |->
      ((i_data & byte_mask) == (i_head_data & byte_mask)) &&
      ((i_data & ~byte_mask) == (old_word & ~byte_mask)))
    else begin
      $error("Merged write data does not combine new bytes with the old word");
      fail_cnt++;
    end

  // RMW read goes out only once non-posted traffic has drained
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_state == ST_SEND_READ) && i_cmd_valid |-> (np_open == '0))
    else begin
      $error("RMW read issued with non-posted accesses outstanding");
      fail_cnt++;
    end

endmodule

bind rmw_converter rmw_checker u_rmw_checker (
  .i_clk             (i_clk),
  .i_rst_n           (i_rst_n),
  .i_cmd_valid       (o_mcmd_valid),
  .i_cmd_accept      (i_scmd_accept),
  .i_cmd             (o_mcmd),
  .i_id              (o_mid),
  .i_addr            (o_maddr),
  .i_data            (o_mdata),
  .i_mst_resp_valid  (i_sresp_valid),
  .i_mst_resp_accept (o_mresp_accept),
  .i_mst_resp_data   (i_sdata),
  .i_resp_valid      (o_sresp_valid),
  .i_resp_accept     (i_mresp_accept),
  .i_resp            (o_sresp),
  .i_resp_id         (o_sid),
  .i_resp_data       (o_sdata),
  .i_state           (state),
  .i_head_byteen     (h_byteen),
  .i_head_data       (h_data)
);

`default_nettype wire

/* dv/rmw_tb.sv */
//----------------------------------------------------------------------------
// RMW subsystem testbench
// Table-driven commands checked against a reference memory, with random
// response stalls on the slave response channel
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_tb;
  import rmw_pkg::*;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 8;
  localparam int CYCLES_PER_ENTRY = 40;

  typedef struct packed {
    bus_cmd_e            cmd;
    logic [ID_W-1:0]     id;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [BYTEEN_W-1:0] byteen;
  } stim_t;

  typedef struct packed {
    bus_resp_e         kind;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
  } exp_t;

  logic                i_clk;
  logic                i_rst_n;
  logic                i_mcmd_valid;
  logic                o_scmd_accept;
  bus_cmd_e            i_mcmd;
  logic [ID_W-1:0]     i_mid;
  logic [ADDR_W-1:0]   i_maddr;
  logic [DATA_W-1:0]   i_mdata;
  logic [BYTEEN_W-1:0] i_mbyteen;
  logic                o_sresp_valid;
  logic                i_mresp_accept;
  bus_resp_e           o_sresp;
  logic [ID_W-1:0]     o_sid;
  logic [DATA_W-1:0]   o_sdata;

  stim_t             table_q [$];
  exp_t              exp_q [$];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  logic [31:0]       rng_state;
  logic              table_built;

  rmw_subsystem u_rmw_subsystem (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .o_scmd_accept  (o_scmd_accept),
    .i_mcmd         (i_mcmd),
    .i_mid          (i_mid),
    .i_maddr        (i_maddr),
    .i_mdata        (i_mdata),
    .i_mbyteen      (i_mbyteen),
    .o_sresp_valid  (o_sresp_valid),
    .i_mresp_accept (i_mresp_accept),
    .o_sresp        (o_sresp),
    .o_sid          (o_sid),
    .o_sdata        (o_sdata)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Enabled bytes come from the new data, the rest keep the old word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BYTEEN_W-1:0] byteen);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < BYTEEN_W; b++) begin
      if (byteen[b]) begin
        result[8*b+:8] = new_word[8*b+:8];
      end
    end
    return result;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] expected);
    stop_with_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  task automatic add_entry(input bus_cmd_e cmd, input logic [ID_W-1:0] id,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [BYTEEN_W-1:0] byteen);
    table_q.push_back('{cmd, id, addr, data, byteen});
  endtask

  task automatic build_table();
    // Full write then read, partial write then read
    add_entry(CMD_WRITE,    4'h1, 4'h1, 32'h1122_3344, 4'hf);
    add_entry(CMD_READ,     4'h2, 4'h1, 32'h0,         4'hf);
    add_entry(CMD_WRITE,    4'h3, 4'h1, 32'haabb_ccdd, 4'h5);
    add_entry(CMD_READ,     4'h4, 4'h1, 32'h0,         4'hf);
    // Non-posted write, then a write with no byte enabled
    add_entry(CMD_WRITE_NP, 4'h5, 4'h2, 32'hcafe_f00d, 4'hf);
    add_entry(CMD_READ,     4'h6, 4'h2, 32'h0,         4'hf);
    add_entry(CMD_WRITE,    4'h7, 4'h2, 32'hffff_ffff, 4'h0);
    add_entry(CMD_READ,     4'h8, 4'h2, 32'h0,         4'hf);
    // Back-to-back mixed traffic
    add_entry(CMD_WRITE_NP, 4'h9, 4'h3, 32'h0123_4567, 4'hf);
    add_entry(CMD_WRITE,    4'ha, 4'h4, 32'h89ab_cdef, 4'hf);
    add_entry(CMD_READ,     4'hb, 4'h3, 32'h0,         4'hf);
    add_entry(CMD_READ,     4'hc, 4'h4, 32'h0,         4'hf);
    add_entry(CMD_WRITE_NP, 4'hd, 4'h4, 32'h0000_5a00, 4'h2);
    add_entry(CMD_READ,     4'he, 4'h4, 32'h0,         4'hf);
    // Partial writes behind several outstanding non-posted writes
    add_entry(CMD_WRITE_NP, 4'h0, 4'h5, 32'h5555_5555, 4'hf);
    add_entry(CMD_WRITE_NP, 4'h1, 4'h6, 32'h6666_6666, 4'hf);
    add_entry(CMD_WRITE_NP, 4'h2, 4'h7, 32'h7777_7777, 4'hf);
    add_entry(CMD_WRITE_NP, 4'h3, 4'h8, 32'h8888_8888, 4'hf);
    add_entry(CMD_WRITE_NP, 4'h4, 4'h9, 32'h9999_9999, 4'hf);
    add_entry(CMD_WRITE,    4'h5, 4'h5, 32'h0000_00ab, 4'h1);
    add_entry(CMD_WRITE_NP, 4'h6, 4'h6, 32'hcd00_0000, 4'h8);
    add_entry(CMD_READ,     4'h7, 4'h5, 32'h0,         4'hf);
    add_entry(CMD_READ,     4'h8, 4'h6, 32'h0,         4'hf);
    add_entry(CMD_READ,     4'h9, 4'h7, 32'h0,         4'hf);
    add_entry(CMD_WRITE_NP, 4'ha, 4'h9, 32'h1234_5678, 4'hc);
    add_entry(CMD_READ,     4'hb, 4'h9, 32'h0,         4'hf);
  endtask

  // Reference memory and expected response queue, in command order
  task automatic model_command(input stim_t s);
    if (s.cmd == CMD_READ) begin
      exp_q.push_back('{RESP_READ_DATA, s.id, ref_mem[s.addr]});
    end else begin
      ref_mem[s.addr] = merge_bytes(ref_mem[s.addr], s.data, s.byteen);
      if (s.cmd == CMD_WRITE_NP) begin
        exp_q.push_back('{RESP_WRITE_ACK, s.id, '0});
      end
    end
  endtask

  // Called on a rising edge, returns on the edge of the handshake
  task automatic send_command(input stim_t s);
    i_mcmd_valid <= 1'b1;
    i_mcmd       <= s.cmd;
    i_mid        <= s.id;
    i_maddr      <= s.addr;
    i_mdata      <= s.data;
    i_mbyteen    <= s.byteen;
    @(posedge i_clk);
    while (!o_scmd_accept) begin
      @(posedge i_clk);
    end
    model_command(s);
  endtask

  task automatic check_response();
    exp_t e;
    assert (exp_q.size() != 0)
      else stop_with_failure("A response arrived while none was expected");
    e = exp_q.pop_front();
    assert (o_sresp == e.kind) else fail_value("o_sresp", DATA_W'(o_sresp), DATA_W'(e.kind));
    assert (o_sid == e.id) else fail_value("o_sid", DATA_W'(o_sid), DATA_W'(e.id));
    if (e.kind == RESP_READ_DATA) begin
      assert (o_sdata == e.data) else fail_value("o_sdata", o_sdata, e.data);
    end
  endtask

  //--------------------------------------------------------------------------
  // Processes
  //--------------------------------------------------------------------------
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      rng_state = xorshift32(rng_state);
      i_mresp_accept <= (rng_state[2:0] > 3'd1);
    end
  end

  always @(posedge i_clk) begin
    if (i_rst_n && o_sresp_valid && i_mresp_accept) begin
      check_response();
    end
  end

  always @(posedge i_clk) begin
    assert (u_rmw_subsystem.u_converter.u_rmw_checker.fail_cnt == 0)
      else stop_with_failure("A bound protocol assertion in the converter failed");
  end

  initial begin : watchdog
    wait (table_built);
    repeat (RESET_CYCLES + CYCLES_PER_ENTRY * table_q.size()) @(posedge i_clk);
    stop_with_failure("Timeout, the responses did not all arrive in time");
  end

  initial begin
    i_clk          = 1'b0;
    i_rst_n        = 1'b0;
    i_mcmd_valid   = 1'b0;
    i_mcmd         = CMD_READ;
    i_mid          = '0;
    i_maddr        = '0;
    i_mdata        = '0;
    i_mbyteen      = '0;
    i_mresp_accept = 1'b0;
    rng_state      = 32'h6354_cde6;
    for (int w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = '0;
    end
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    repeat (2) @(posedge i_clk);
    foreach (table_q[i]) begin
      send_command(table_q[i]);
    end
    i_mcmd_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    // Extra responses in this window hit the empty-queue check
    repeat (10) @(posedge i_clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/rmw_converter.sv */
//----------------------------------------------------------------------------
// RMW converter
// Passes full-word traffic through and turns byte-masked writes into a
// read, a byte merge and a whole-word write
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_converter (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  // Slave command
  input  var logic                           i_mcmd_valid,
  output var logic                           o_scmd_accept,
  input  var rmw_pkg::bus_cmd_e              i_mcmd,
  input  var logic [rmw_pkg::ID_W-1:0]       i_mid,
  input  var logic [rmw_pkg::ADDR_W-1:0]     i_maddr,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_mdata,
  input  var logic [rmw_pkg::BYTEEN_W-1:0]   i_mbyteen,
  // Slave response
  output var logic                           o_sresp_valid,
  input  var logic                           i_mresp_accept,
  output var rmw_pkg::bus_resp_e             o_sresp,
  output var logic [rmw_pkg::ID_W-1:0]       o_sid,
  output var logic [rmw_pkg::DATA_W-1:0]     o_sdata,
  // Master command
  output var logic                           o_mcmd_valid,
  input  var logic                           i_scmd_accept,
  output var rmw_pkg::bus_cmd_e              o_mcmd,
  output var logic [rmw_pkg::ID_W-1:0]       o_mid,
  output var logic [rmw_pkg::ADDR_W-1:0]     o_maddr,
  output var logic [rmw_pkg::DATA_W-1:0]     o_mdata,
  // Master response
  input  var logic                           i_sresp_valid,
  output var logic                           o_mresp_accept,
  input  var rmw_pkg::bus_resp_e             i_sresp,
  input  var logic [rmw_pkg::ID_W-1:0]       i_sid,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_sdata
);
  import rmw_pkg::*;

  rmw_state_e          state;
  logic                fifo_full;
  logic                fifo_empty;
  logic                fifo_pop;
  bus_cmd_e            h_cmd;
  logic [ID_W-1:0]     h_id;
  logic [ADDR_W-1:0]   h_addr;
  logic [DATA_W-1:0]   h_data;
  logic [BYTEEN_W-1:0] h_byteen;
  logic                h_partial;
  logic [NP_CNT_W-1:0] np_cnt;
  logic                np_full;
  logic                cmd_ack;
  logic                resp_ack;
  logic [DATA_W-1:0]   read_word;
  logic [DATA_W-1:0]   merged_data;

  assign o_scmd_accept = !fifo_full;

  rmw_req_fifo u_req_fifo (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_push   (i_mcmd_valid),
    .i_cmd    (i_mcmd),
    .i_id     (i_mid),
    .i_addr   (i_maddr),
    .i_data   (i_mdata),
    .i_byteen (i_mbyteen),
    .o_full   (fifo_full),
    .o_empty  (fifo_empty),
    .i_pop    (fifo_pop),
    .o_cmd    (h_cmd),
    .o_id     (h_id),
    .o_addr   (h_addr),
    .o_data   (h_data),
    .o_byteen (h_byteen)
  );

  // A write with any byte enable clear needs the old word first
  assign h_partial = (h_cmd != CMD_READ) && (h_byteen != '1);
  assign np_full   = (np_cnt == NP_CNT_W'(MAX_NP));
  assign cmd_ack   = o_mcmd_valid && i_scmd_accept;
  assign resp_ack  = i_sresp_valid && o_mresp_accept;

  //--------------------------------------------------------------------------
  // Master command
  //--------------------------------------------------------------------------
  always_comb begin
    case (state)
      ST_PASS:         o_mcmd_valid = !fifo_empty && !h_partial && !np_full;
      ST_SEND_READ:    o_mcmd_valid = (np_cnt == '0);
      ST_WRITE_MERGED: o_mcmd_valid = 1'b1;
      default:         o_mcmd_valid = 1'b0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < BYTEEN_W; i++) begin
      merged_data[8*i+:8] = h_byteen[i] ? h_data[8*i+:8] : read_word[8*i+:8];
    end
  end

  assign o_mcmd   = (state == ST_SEND_READ) ? CMD_READ : h_cmd;
  assign o_mid    = h_id;
  assign o_maddr  = h_addr;
  assign o_mdata  = (state == ST_WRITE_MERGED) ? merged_data : h_data;
  assign fifo_pop = cmd_ack && ((state == ST_PASS) || (state == ST_WRITE_MERGED));

  // Response steering, read data for the merge stays inside
  assign o_mresp_accept = (state == ST_WAIT_READ) ? 1'b1 : i_mresp_accept;
  assign o_sresp_valid  = (state == ST_WAIT_READ) ? 1'b0 : i_sresp_valid;
  assign o_sresp        = i_sresp;
  assign o_sid          = i_sid;
  assign o_sdata        = i_sdata;

  //--------------------------------------------------------------------------
  // State and non-posted counter
  //--------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_PASS;
    end else begin
      case (state)
        ST_PASS: begin
          if (!fifo_empty && h_partial) begin
            state <= ST_SEND_READ;
          end
        end
        ST_SEND_READ: begin
          if (cmd_ack) begin
            state <= ST_WAIT_READ;
          end
        end
        ST_WAIT_READ: begin
          if (resp_ack) begin
            state <= ST_WRITE_MERGED;
          end
        end
        default: begin
          if (cmd_ack) begin
            state <= ST_PASS;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      np_cnt <= '0;
    end else begin
      case ({cmd_ack && (o_mcmd != CMD_WRITE), resp_ack})
        2'b10:   np_cnt <= np_cnt + NP_CNT_W'(1);
        2'b01:   np_cnt <= np_cnt - NP_CNT_W'(1);
        default: np_cnt <= np_cnt;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == ST_WAIT_READ) && resp_ack) begin
      read_word <= i_sdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/rmw_pkg.sv */
//----------------------------------------------------------------------------
// RMW subsystem package
// Bus widths, limits, and command, response and converter state encodings
//----------------------------------------------------------------------------
`default_nettype none

package rmw_pkg;

  // Bus geometry
  localparam int DATA_W    = 32;
  localparam int BYTEEN_W  = DATA_W / 8;
  localparam int ID_W      = 4;
  localparam int ADDR_W    = 4;
  localparam int MEM_WORDS = 16;

  // Outstanding non-posted limit and its counter width
  localparam int MAX_NP    = 4;
  localparam int NP_CNT_W  = 3;

  typedef enum logic [1:0] {
    CMD_READ,
    CMD_WRITE,
    CMD_WRITE_NP
  } bus_cmd_e;

  typedef enum logic {
    RESP_READ_DATA,
    RESP_WRITE_ACK
  } bus_resp_e;

  typedef enum logic [1:0] {
    ST_PASS,
    ST_SEND_READ,
    ST_WAIT_READ,
    ST_WRITE_MERGED
  } rmw_state_e;

endpackage

`default_nettype wire

/* hdl/rmw_req_fifo.sv */
//----------------------------------------------------------------------------
// Request FIFO
// Two-entry command buffer ahead of the RMW converter logic
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_req_fifo (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_push,
  input  var rmw_pkg::bus_cmd_e              i_cmd,
  input  var logic [rmw_pkg::ID_W-1:0]       i_id,
  input  var logic [rmw_pkg::ADDR_W-1:0]     i_addr,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_data,
  input  var logic [rmw_pkg::BYTEEN_W-1:0]   i_byteen,
  output var logic                           o_full,
  output var logic                           o_empty,
  input  var logic                           i_pop,
  output var rmw_pkg::bus_cmd_e              o_cmd,
  output var logic [rmw_pkg::ID_W-1:0]       o_id,
  output var logic [rmw_pkg::ADDR_W-1:0]     o_addr,
  output var logic [rmw_pkg::DATA_W-1:0]     o_data,
  output var logic [rmw_pkg::BYTEEN_W-1:0]   o_byteen
);
  import rmw_pkg::*;

  // Pointers carry a wrap bit above the one-bit slot index
  logic [1:0]          wr_ptr;
  logic [1:0]          rd_ptr;
  logic                wr_en;
  logic                rd_en;
  bus_cmd_e            cmd_mem    [2];
  logic [ID_W-1:0]     id_mem     [2];
  logic [ADDR_W-1:0]   addr_mem   [2];
  logic [DATA_W-1:0]   data_mem   [2];
  logic [BYTEEN_W-1:0] byteen_mem [2];

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[1] != rd_ptr[1]) && (wr_ptr[0] == rd_ptr[0]);
  assign wr_en   = i_push && !o_full;
  assign rd_en   = i_pop && !o_empty;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      cmd_mem[wr_ptr[0]]    <= i_cmd;
      id_mem[wr_ptr[0]]     <= i_id;
      addr_mem[wr_ptr[0]]   <= i_addr;
      data_mem[wr_ptr[0]]   <= i_data;
      byteen_mem[wr_ptr[0]] <= i_byteen;
    end
  end

  // Head entry
  assign o_cmd    = cmd_mem[rd_ptr[0]];
  assign o_id     = id_mem[rd_ptr[0]];
  assign o_addr   = addr_mem[rd_ptr[0]];
  assign o_data   = data_mem[rd_ptr[0]];
  assign o_byteen = byteen_mem[rd_ptr[0]];

endmodule

`default_nettype wire

/* hdl/rmw_slicer.sv */
//----------------------------------------------------------------------------
// Master-side register slice
// One registered stage each for the command and the response channel
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_slicer (
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  // Upstream
  input  var logic                         i_mcmd_valid,
  output var logic                         o_scmd_accept,
  input  var rmw_pkg::bus_cmd_e            i_mcmd,
  input  var logic [rmw_pkg::ID_W-1:0]     i_mid,
  input  var logic [rmw_pkg::ADDR_W-1:0]   i_maddr,
  input  var logic [rmw_pkg::DATA_W-1:0]   i_mdata,
  output var logic                         o_sresp_valid,
  input  var logic                         i_mresp_accept,
  output var rmw_pkg::bus_resp_e           o_sresp,
  output var logic [rmw_pkg::ID_W-1:0]     o_sid,
  output var logic [rmw_pkg::DATA_W-1:0]   o_sdata,
  // Downstream
  output var logic                         o_mcmd_valid,
  input  var logic                         i_scmd_accept,
  output var rmw_pkg::bus_cmd_e            o_mcmd,
  output var logic [rmw_pkg::ID_W-1:0]     o_mid,
  output var logic [rmw_pkg::ADDR_W-1:0]   o_maddr,
  output var logic [rmw_pkg::DATA_W-1:0]   o_mdata,
  input  var logic                         i_sresp_valid,
  output var logic                         o_mresp_accept,
  input  var rmw_pkg::bus_resp_e           i_sresp,
  input  var logic [rmw_pkg::ID_W-1:0]     i_sid,
  input  var logic [rmw_pkg::DATA_W-1:0]   i_sdata
);
  import rmw_pkg::*;

  // Each stage takes a new item when empty or when its held item leaves
  assign o_scmd_accept  = !o_mcmd_valid || i_scmd_accept;
  assign o_mresp_accept = !o_sresp_valid || i_mresp_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_mcmd_valid  <= 1'b0;
      o_sresp_valid <= 1'b0;
    end else begin
      if (o_scmd_accept) begin
        o_mcmd_valid <= i_mcmd_valid;
      end
      if (o_mresp_accept) begin
        o_sresp_valid <= i_sresp_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mcmd_valid && o_scmd_accept) begin
      o_mcmd  <= i_mcmd;
      o_mid   <= i_mid;
      o_maddr <= i_maddr;
      o_mdata <= i_mdata;
    end
    if (i_sresp_valid && o_mresp_accept) begin
      o_sresp <= i_sresp;
      o_sid   <= i_sid;
      o_sdata <= i_sdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/rmw_subsystem.sv */
//----------------------------------------------------------------------------
// RMW subsystem top level
// Converter, master-side slice and word-only target
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_subsystem (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_mcmd_valid,
  output var logic                           o_scmd_accept,
  input  var rmw_pkg::bus_cmd_e              i_mcmd,
  input  var logic [rmw_pkg::ID_W-1:0]       i_mid,
  input  var logic [rmw_pkg::ADDR_W-1:0]     i_maddr,
  input  var logic [rmw_pkg::DATA_W-1:0]     i_mdata,
  input  var logic [rmw_pkg::BYTEEN_W-1:0]   i_mbyteen,
  output var logic                           o_sresp_valid,
  input  var logic                           i_mresp_accept,
  output var rmw_pkg::bus_resp_e             o_sresp,
  output var logic [rmw_pkg::ID_W-1:0]       o_sid,
  output var logic [rmw_pkg::DATA_W-1:0]     o_sdata
);
  import rmw_pkg::*;

  // Converter to slice
  logic              cv_cmd_valid;
  logic              cv_cmd_accept;
  bus_cmd_e          cv_cmd;
  logic [ID_W-1:0]   cv_id;
  logic [ADDR_W-1:0] cv_addr;
  logic [DATA_W-1:0] cv_data;
  logic              cv_resp_valid;
  logic              cv_resp_accept;
  bus_resp_e         cv_resp;
  logic [ID_W-1:0]   cv_resp_id;
  logic [DATA_W-1:0] cv_resp_data;

  // Slice to target
  logic              tg_cmd_valid;
  logic              tg_cmd_accept;
  bus_cmd_e          tg_cmd;
  logic [ID_W-1:0]   tg_id;
  logic [ADDR_W-1:0] tg_addr;
  logic [DATA_W-1:0] tg_data;
  logic              tg_resp_valid;
  logic              tg_resp_accept;
  bus_resp_e         tg_resp;
  logic [ID_W-1:0]   tg_resp_id;
  logic [DATA_W-1:0] tg_resp_data;

  rmw_converter u_converter (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .o_scmd_accept  (o_scmd_accept),
    .i_mcmd         (i_mcmd),
    .i_mid          (i_mid),
    .i_maddr        (i_maddr),
    .i_mdata        (i_mdata),
    .i_mbyteen      (i_mbyteen),
    .o_sresp_valid  (o_sresp_valid),
    .i_mresp_accept (i_mresp_accept),
    .o_sresp        (o_sresp),
    .o_sid          (o_sid),
    .o_sdata        (o_sdata),
    .o_mcmd_valid   (cv_cmd_valid),
    .i_scmd_accept  (cv_cmd_accept),
    .o_mcmd         (cv_cmd),
    .o_mid          (cv_id),
    .o_maddr        (cv_addr),
    .o_mdata        (cv_data),
    .i_sresp_valid  (cv_resp_valid),
    .o_mresp_accept (cv_resp_accept),
    .i_sresp        (cv_resp),
    .i_sid          (cv_resp_id),
    .i_sdata        (cv_resp_data)
  );

  rmw_slicer u_slicer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (cv_cmd_valid),
    .o_scmd_accept  (cv_cmd_accept),
    .i_mcmd         (cv_cmd),
    .i_mid          (cv_id),
    .i_maddr        (cv_addr),
    .i_mdata        (cv_data),
    .o_sresp_valid  (cv_resp_valid),
    .i_mresp_accept (cv_resp_accept),
    .o_sresp        (cv_resp),
    .o_sid          (cv_resp_id),
    .o_sdata        (cv_resp_data),
    .o_mcmd_valid   (tg_cmd_valid),
    .i_scmd_accept  (tg_cmd_accept),
    .o_mcmd         (tg_cmd),
    .o_mid          (tg_id),
    .o_maddr        (tg_addr),
    .o_mdata        (tg_data),
    .i_sresp_valid  (tg_resp_valid),
    .o_mresp_accept (tg_resp_accept),
    .i_sresp        (tg_resp),
    .i_sid          (tg_resp_id),
    .i_sdata        (tg_resp_data)
  );

  rmw_word_target u_target (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (tg_cmd_valid),
    .o_scmd_accept  (tg_cmd_accept),
    .i_mcmd         (tg_cmd),
    .i_mid          (tg_id),
    .i_maddr        (tg_addr),
    .i_mdata        (tg_data),
    .o_sresp_valid  (tg_resp_valid),
    .i_mresp_accept (tg_resp_accept),
    .o_sresp        (tg_resp),
    .o_sid          (tg_resp_id),
    .o_sdata        (tg_resp_data)
  );

endmodule

`default_nettype wire

/* hdl/rmw_word_target.sv */
//----------------------------------------------------------------------------
// Word-only memory target
// 16-word store with a one-entry response register
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_word_target (
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  input  var logic                         i_mcmd_valid,
  output var logic                         o_scmd_accept,
  input  var rmw_pkg::bus_cmd_e            i_mcmd,
  input  var logic [rmw_pkg::ID_W-1:0]     i_mid,
  input  var logic [rmw_pkg::ADDR_W-1:0]   i_maddr,
  input  var logic [rmw_pkg::DATA_W-1:0]   i_mdata,
  output var logic                         o_sresp_valid,
  input  var logic                         i_mresp_accept,
  output var rmw_pkg::bus_resp_e           o_sresp,
  output var logic [rmw_pkg::ID_W-1:0]     o_sid,
  output var logic [rmw_pkg::DATA_W-1:0]   o_sdata
);
  import rmw_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              cmd_ack;
  logic              needs_resp;

  // Held response blocks new commands
  assign o_scmd_accept = !o_sresp_valid || i_mresp_accept;
  assign cmd_ack       = i_mcmd_valid && o_scmd_accept;
  assign needs_resp    = (i_mcmd != CMD_WRITE);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (cmd_ack && (i_mcmd != CMD_READ)) begin
      mem[i_maddr] <= i_mdata;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sresp_valid <= 1'b0;
    end else if (o_scmd_accept) begin
      o_sresp_valid <= cmd_ack && needs_resp;
    end
  end

  // Read returns the stored word, an acknowledge carries zero data
  always_ff @(posedge i_clk) begin
    if (cmd_ack && needs_resp) begin
      o_sresp <= (i_mcmd == CMD_READ) ? RESP_READ_DATA : RESP_WRITE_ACK;
      o_sid   <= i_mid;
      o_sdata <= (i_mcmd == CMD_READ) ? mem[i_maddr] : '0;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compile and run the RMW subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module rmw_tb -o rmw_sim

# The simulator exit status is not trusted, the log decides
./obj_dir/rmw_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^All checks passed$" sim.log; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi

/* vlog.f */
hdl/rmw_pkg.sv
hdl/rmw_req_fifo.sv
hdl/rmw_converter.sv
hdl/rmw_slicer.sv
hdl/rmw_word_target.sv
hdl/rmw_subsystem.sv
dv/rmw_checker.sv
dv/rmw_tb.sv
